//--- src/vec_exe_pkg.sv
// ====================
// Vector execute stage shared widths,
// vector types, operation encodings and structs
// ====================
`default_nettype none

package vec_exe_pkg;

    localparam int vlen       = 128;
    localparam int vlenb      = vlen / 8;
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [vlen-1:0]       vec_data_t;
    typedef logic [vlenb-1:0]      vec_byte_mask_t;
    // One bit per element index, only the low vlen/SEW bits matter
    typedef logic [vlenb-1:0]      vec_mask_t;
    typedef logic [xlen-1:0]       xlen_data_t;
    typedef logic [4:0]            vec_imm_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    // Range 0 to 16
    typedef logic [4:0]            vl_t;
    typedef logic [3:0]            vstart_t;

    // Same encoding as vtype.vsew
    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2
    } sew_e;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_sra = 4'd7,
        op_min = 4'd8,
        op_max = 4'd9
    } vec_op_e;

    // Operand B kind
    typedef enum logic [1:0] {
        src_vv = 2'd0,
        src_vx = 2'd1,
        src_vi = 2'd2
    } src_sel_e;

    typedef struct packed {
        vec_op_e    op;
        src_sel_e   src_sel;
        logic       is_signed;
        logic       use_mask;
        sew_e       sew;
        vl_t        vl;
        vstart_t    vstart;
        reg_addr_t  srca_addr;
        reg_addr_t  srcb_addr;
        reg_addr_t  vd_addr;
        vec_data_t  srca;
        vec_data_t  srcb;
        vec_data_t  vd_old;
        vec_data_t  mask_reg;
        xlen_data_t scalar;
        vec_imm_t   imm;
    } vec_op_t;

    // Register write from a later pipeline stage
    typedef struct packed {
        logic      wr_en;
        reg_addr_t addr;
        vec_data_t data;
    } fwd_port_t;

    typedef struct packed {
        vec_data_t data;
        reg_addr_t vd_addr;
    } vec_result_t;

endpackage

`default_nettype wire

//--- src/vec_bypass.sv
// ====================
// Operand forwarding from mem and wb stages
// Scalar and immediate broadcast for operand B
// ====================
`timescale 1ns/1ns
`default_nettype none

module vec_bypass (
    input  vec_exe_pkg::vec_op_t   op,
    input  vec_exe_pkg::fwd_port_t fwd_mem,
    input  vec_exe_pkg::fwd_port_t fwd_wb,
    output vec_exe_pkg::vec_data_t srca_byp,
    output vec_exe_pkg::vec_data_t srcb_opnd,
    output vec_exe_pkg::vec_data_t vd_old_byp,
    output vec_exe_pkg::vec_data_t mask_byp
);
    import vec_exe_pkg::*;

    vec_data_t  srcb_byp;
    xlen_data_t imm_ext;

    // Memory stage holds the newer value, so it wins over write-back
    function automatic vec_data_t fwd_pick(reg_addr_t addr, vec_data_t own,
                                           fwd_port_t mem, fwd_port_t wb);
        if (mem.wr_en && (mem.addr == addr)) begin
            return mem.data;
        end
        if (wb.wr_en && (wb.addr == addr)) begin
            return wb.data;
        end
        return own;
    endfunction

    // Replicate the low SEW bits into every element
    function automatic vec_data_t broadcast(xlen_data_t val, sew_e width);
        case (width)
            sew8:    return {vlenb{val[7:0]}};
            sew16:   return {(vlenb/2){val[15:0]}};
            default: return {(vlen/xlen){val}};
        endcase
    endfunction

    assign srca_byp   = fwd_pick(op.srca_addr, op.srca, fwd_mem, fwd_wb);
    assign srcb_byp   = fwd_pick(op.srcb_addr, op.srcb, fwd_mem, fwd_wb);
    assign vd_old_byp = fwd_pick(op.vd_addr, op.vd_old, fwd_mem, fwd_wb);
    // Mask always lives in v0
    assign mask_byp   = fwd_pick(reg_addr_t'(0), op.mask_reg, fwd_mem, fwd_wb);

    assign imm_ext = {{(xlen-$bits(vec_imm_t)){op.imm[$bits(vec_imm_t)-1]}}, op.imm};

    always_comb begin
        case (op.src_sel)
            src_vx:  srcb_opnd = broadcast(op.scalar, op.sew);
            src_vi:  srcb_opnd = broadcast(imm_ext, op.sew);
            default: srcb_opnd = srcb_byp;
        endcase
    end

endmodule

`default_nettype wire

//--- src/vec_element_ctrl.sv
// ====================
// Active element decode from vl, vstart,
// SEW and the v0 mask, expanded to bytes
// ====================
`timescale 1ns/1ns
`default_nettype none

module vec_element_ctrl (
    input  vec_exe_pkg::sew_e           sew,
    input  vec_exe_pkg::vl_t            vl,
    input  vec_exe_pkg::vstart_t        vstart,
    input  logic                        use_mask,
    input  vec_exe_pkg::vec_data_t      mask_reg,
    output vec_exe_pkg::vec_byte_mask_t byte_en
);
    import vec_exe_pkg::*;

    vec_mask_t mask_bits;
    vec_mask_t elem_act;

    // Bit i of v0 belongs to element i
    assign mask_bits = mask_reg[$bits(vec_mask_t)-1:0];

    // Per element index, independent of SEW
    always_comb begin
        for (int i = 0; i < $bits(vec_mask_t); i++) begin
            elem_act[i] = (vstart <= vstart_t'(i))
                       && (vl_t'(i) < vl)
                       && (!use_mask || mask_bits[i]);
        end
    end

    // Byte b sits in element b/(SEW/8)
    // Indices beyond vlen/SEW are never reached, so missing elements stay off
    always_comb begin
        for (int b = 0; b < vlenb; b++) begin
            case (sew)
                sew8:    byte_en[b] = elem_act[b];
                sew16:   byte_en[b] = elem_act[b/2];
                default: byte_en[b] = elem_act[b/4];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/vec_lane_alu.sv
// ====================
// Element-wise vector ALU at SEW 8, 16 and 32
// Byte merge with the old destination
// ====================
`timescale 1ns/1ns
`default_nettype none

module vec_lane_alu (
    input  vec_exe_pkg::vec_op_e        op,
    input  logic                        is_signed,
    input  vec_exe_pkg::sew_e           sew,
    input  vec_exe_pkg::vec_data_t      srca,
    input  vec_exe_pkg::vec_data_t      srcb,
    input  vec_exe_pkg::vec_data_t      vd_old,
    input  vec_exe_pkg::vec_byte_mask_t byte_en,
    output vec_exe_pkg::vec_data_t      result
);
    import vec_exe_pkg::*;

    vec_data_t res8;
    vec_data_t res16;
    vec_data_t res32;
    vec_data_t alu_res;

    // One element, operands arrive zero extended to xlen
    // Only the low width bits of the return value are meaningful
    function automatic xlen_data_t lane_op(vec_op_e opc, logic sgn, sew_e width,
                                           xlen_data_t a, xlen_data_t b);
        xlen_data_t a_s;
        xlen_data_t b_s;
        logic [4:0] shamt;
        logic       a_lt_b;
        case (width)
            sew8: begin
                a_s   = {{24{a[7]}}, a[7:0]};
                b_s   = {{24{b[7]}}, b[7:0]};
                shamt = {2'b00, b[2:0]};
            end
            sew16: begin
                a_s   = {{16{a[15]}}, a[15:0]};
                b_s   = {{16{b[15]}}, b[15:0]};
                shamt = {1'b0, b[3:0]};
            end
            default: begin
                a_s   = a;
                b_s   = b;
                shamt = b[4:0];
            end
        endcase
        a_lt_b = sgn ? ($signed(a_s) < $signed(b_s)) : (a < b);
        case (opc)
            op_add:  lane_op = a + b;
            op_sub:  lane_op = a - b;
            op_and:  lane_op = a & b;
            op_or:   lane_op = a | b;
            op_xor:  lane_op = a ^ b;
            op_sll:  lane_op = a << shamt;
            // Zero extension feeds zeros in from the top
            op_srl:  lane_op = a >> shamt;
            op_sra:  lane_op = xlen_data_t'($signed(a_s) >>> shamt);
            op_min:  lane_op = a_lt_b ? a : b;
            op_max:  lane_op = a_lt_b ? b : a;
            default: lane_op = '0;
        endcase
    endfunction

    // All three widths in parallel, carries end at each element boundary
    always_comb begin
        for (int i = 0; i < vlenb; i++) begin
            res8[8*i +: 8] = 8'(lane_op(op, is_signed, sew8,
                                        xlen_data_t'(srca[8*i +: 8]),
                                        xlen_data_t'(srcb[8*i +: 8])));
        end
        for (int i = 0; i < vlenb/2; i++) begin
            res16[16*i +: 16] = 16'(lane_op(op, is_signed, sew16,
                                            xlen_data_t'(srca[16*i +: 16]),
                                            xlen_data_t'(srcb[16*i +: 16])));
        end
        for (int i = 0; i < vlen/xlen; i++) begin
            res32[32*i +: 32] = lane_op(op, is_signed, sew32,
                                        srca[32*i +: 32],
                                        srcb[32*i +: 32]);
        end
    end

    always_comb begin
        case (sew)
            sew8:    alu_res = res8;
            sew16:   alu_res = res16;
            default: alu_res = res32;
        endcase
    end

    // Inactive bytes keep the old destination
    always_comb begin
        for (int b = 0; b < vlenb; b++) begin
            result[8*b +: 8] = byte_en[b] ? alu_res[8*b +: 8] : vd_old[8*b +: 8];
        end
    end

endmodule

`default_nettype wire

//--- src/vec_execute.sv
// ====================
// Vector execute stage top
// Bypass, element control, ALU and output register
// ====================
`timescale 1ns/1ns
`default_nettype none

module vec_execute (
    input  logic                     clk,
    input  logic                     arst_n,
    input  vec_exe_pkg::vec_op_t     in_op,
    input  logic                     in_valid,
    input  logic                     out_ready,
    input  vec_exe_pkg::fwd_port_t   fwd_mem,
    input  vec_exe_pkg::fwd_port_t   fwd_wb,
    output logic                     in_ready,
    output vec_exe_pkg::vec_result_t out_res,
    output logic                     out_valid
);
    import vec_exe_pkg::*;

    vec_data_t      srca_byp;
    vec_data_t      srcb_opnd;
    vec_data_t      vd_old_byp;
    vec_data_t      mask_byp;
    vec_byte_mask_t byte_en;
    vec_data_t      alu_result;
    logic           accept;

    vec_bypass u_bypass (
        .op         (in_op),
        .fwd_mem    (fwd_mem),
        .fwd_wb     (fwd_wb),
        .srca_byp   (srca_byp),
        .srcb_opnd  (srcb_opnd),
        .vd_old_byp (vd_old_byp),
        .mask_byp   (mask_byp)
    );

    vec_element_ctrl u_element_ctrl (
        .sew      (in_op.sew),
        .vl       (in_op.vl),
        .vstart   (in_op.vstart),
        .use_mask (in_op.use_mask),
        .mask_reg (mask_byp),
        .byte_en  (byte_en)
    );

    vec_lane_alu u_lane_alu (
        .op        (in_op.op),
        .is_signed (in_op.is_signed),
        .sew       (in_op.sew),
        .srca      (srca_byp),
        .srcb      (srcb_opnd),
        .vd_old    (vd_old_byp),
        .byte_en   (byte_en),
        .result    (alu_result)
    );

    // Slot is free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_res.data    <= alu_result;
            out_res.vd_addr <= in_op.vd_addr;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_vec_tests.svh
// ====================
// Directed tests, handshake helpers
// and the value check
// ====================
`ifndef TB_VEC_TESTS_SVH
`define TB_VEC_TESTS_SVH

task automatic check_value(input string name, input vec_data_t got, input vec_data_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %s at %0t ns: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
endtask

function automatic vec_data_t random_vec();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
endfunction

// Full-length unmasked vector-vector operation with distinct nonzero addresses
function automatic vec_op_t random_op(vec_op_e opc, sew_e sew);
    vec_op_t op;
    op           = '0;
    op.op        = opc;
    op.src_sel   = src_vv;
    op.sew       = sew;
    op.vl        = vl_t'(vlen / elem_bits(sew));
    op.srca_addr = reg_addr_t'($urandom_range(1, 10));
    op.srcb_addr = reg_addr_t'($urandom_range(11, 20));
    op.vd_addr   = reg_addr_t'($urandom_range(21, 31));
    op.srca      = random_vec();
    op.srcb      = random_vec();
    op.vd_old    = random_vec();
    op.mask_reg  = random_vec();
    op.scalar    = $urandom();
    op.imm       = vec_imm_t'($urandom());
    return op;
endfunction

function automatic fwd_port_t random_port(reg_addr_t addr);
    fwd_port_t port;
    port.wr_en = 1'b1;
    port.addr  = addr;
    port.data  = random_vec();
    return port;
endfunction

task automatic apply_reset();
    in_valid = 1'b0;
    arst_n   = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
endtask

// Entered and left 1 ns after a rising edge
task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
        #1;
        taken = in_valid && in_ready;
        @(posedge clk);
        #1;
    end
endtask

task automatic wait_result(output vec_result_t res);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
        #1;
        seen = out_valid && out_ready;
        res  = out_res;
        @(posedge clk);
        #1;
    end
endtask

task automatic execute_and_check(input vec_op_t op, input fwd_port_t mem,
                                 input fwd_port_t wb, input vec_data_t exp_data);
    vec_result_t res;
    in_op    = op;
    fwd_mem  = mem;
    fwd_wb   = wb;
    in_valid = 1'b1;
    wait_accept();
    in_valid = 1'b0;
    fwd_mem  = fwd_idle;
    fwd_wb   = fwd_idle;
    wait_result(res);
    check_value("out_res.data", res.data, exp_data);
    check_value("out_res.vd_addr", vec_data_t'(res.vd_addr), vec_data_t'(op.vd_addr));
endtask

task automatic run_op(input vec_op_t op);
    execute_and_check(op, fwd_idle, fwd_idle, expected_result(op, fwd_idle, fwd_idle));
endtask

task automatic test_arith_logic();
    vec_op_t op;
    for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 5; k++) begin
            repeat (2) begin
                op = random_op(vec_op_e'(k), sew_e'(s));
                run_op(op);
            end
        end
        // All ones plus one per element
        // A leaking carry would reach the next element
        op      = random_op(op_add, sew_e'(s));
        op.srca = '1;
        op.srcb = replicate(xlen_data_t'(1), sew_e'(s));
        run_op(op);
        op.op   = op_sub;
        op.srca = '0;
        run_op(op);
    end
endtask

task automatic test_shift_minmax();
    vec_op_t op;
    int      w;
    for (int s = 0; s < 3; s++) begin
        w = elem_bits(sew_e'(s));
        for (int k = 5; k < 10; k++) begin
            for (int r = 0; r < 4; r++) begin
                op           = random_op(vec_op_e'(k), sew_e'(s));
                op.is_signed = r[0];
                if (r >= 2) begin
                    // Top bit set in every A element
                    op.srca = op.srca | replicate(xlen_data_t'(1) << (w - 1), sew_e'(s));
                end
                if (r == 3 && k < 8) begin
                    op.srcb = replicate(xlen_data_t'(w - 1), sew_e'(s));
                end
                run_op(op);
            end
        end
    end
endtask

task automatic test_mask_tail();
    vec_op_t op;
    int      n;
    for (int s = 0; s < 3; s++) begin
        n = vlen / elem_bits(sew_e'(s));
        for (int r = 0; r < 6; r++) begin
            op          = random_op(vec_op_e'($urandom_range(0, 9)), sew_e'(s));
            op.use_mask = r[0];
            op.vl       = vl_t'($urandom_range(0, n - 1));
            op.vstart   = vstart_t'($urandom_range(1, n - 1));
            run_op(op);
        end
        // Empty vector returns the old destination untouched
        op    = random_op(op_add, sew_e'(s));
        op.vl = '0;
        execute_and_check(op, fwd_idle, fwd_idle, op.vd_old);
    end
endtask

task automatic test_broadcast();
    vec_op_t op;
    vec_op_t vv_op;
    for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 10; k++) begin
            for (int c = 0; c < 3; c++) begin
                op           = random_op(vec_op_e'(k), sew_e'(s));
                op.is_signed = 1'b1;
                op.src_sel   = (c == 0) ? src_vx : src_vi;
                // Negative immediate in the last pass
                op.imm[4]    = (c == 2);
                vv_op         = op;
                vv_op.src_sel = src_vv;
                vv_op.srcb    = (c == 0) ? replicate(op.scalar, op.sew) :
                                replicate({{(xlen-5){op.imm[4]}}, op.imm}, op.sew);
                execute_and_check(op, fwd_idle, fwd_idle,
                                  expected_result(vv_op, fwd_idle, fwd_idle));
            end
        end
    end
endtask

task automatic test_forwarding();
    vec_op_t   op;
    fwd_port_t mem;
    fwd_port_t wb;
    for (int s = 0; s < 3; s++) begin
        for (int c = 0; c < 6; c++) begin
            op  = random_op(vec_op_e'($urandom_range(0, 9)), sew_e'(s));
            mem = fwd_idle;
            wb  = fwd_idle;
            case (c)
                0: mem = random_port(op.srca_addr);
                1: wb  = random_port(op.srcb_addr);
                2: begin
                    // Tail and start elements expose the forwarded old value
                    mem       = random_port(op.vd_addr);
                    op.vl     = op.vl >> 1;
                    op.vstart = 4'd1;
                end
                3: begin
                    wb          = random_port(reg_addr_t'(0));
                    op.use_mask = 1'b1;
                end
                4: begin
                    // Both stages write srca
                    mem = random_port(op.srca_addr);
                    wb  = random_port(op.srca_addr);
                end
                default: begin
                    mem       = random_port(op.srca_addr);
                    mem.wr_en = 1'b0;
                end
            endcase
            execute_and_check(op, mem, wb, expected_result(op, mem, wb));
        end
    end
endtask

task automatic test_handshake();
    vec_op_t     stream[8];
    vec_data_t   exp_data[8];
    int          acc_cycle[8];
    vec_op_t     op_a;
    vec_op_t     op_b;
    vec_result_t res;
    int          cycle;
    int          sent;
    int          got;
    // Leave a result pending so the reset has something to clear
    out_ready = 1'b0;
    in_op     = random_op(op_add, sew8);
    in_valid  = 1'b1;
    wait_accept();
    in_valid = 1'b0;
    check_value("out_valid", vec_data_t'(out_valid), vec_data_t'(1));
    apply_reset();
    check_value("out_valid", vec_data_t'(out_valid), vec_data_t'(0));
    check_value("in_ready", vec_data_t'(in_ready), vec_data_t'(1));
    for (int k = 0; k < 8; k++) begin
        stream[k]    = random_op(vec_op_e'(k), sew_e'(k % 3));
        exp_data[k]  = expected_result(stream[k], fwd_idle, fwd_idle);
        acc_cycle[k] = -10;
    end
    out_ready = 1'b1;
    cycle     = 0;
    sent      = 0;
    got       = 0;
    while (got < 8) begin
        in_valid = (sent < 8);
        if (sent < 8) begin
            in_op = stream[sent];
        end
        #1;
        if (out_valid) begin
            check_value("out_res.data", out_res.data, exp_data[got]);
            check_value("latency", vec_data_t'(cycle - acc_cycle[got]), vec_data_t'(1));
            got++;
        end
        check_value("in_ready", vec_data_t'(in_ready), vec_data_t'(1));
        if (in_valid && in_ready) begin
            acc_cycle[sent] = cycle;
            sent++;
        end
        @(posedge clk);
        #1;
        cycle++;
    end
    // Consumer stalls with one result held and the next operation waiting
    op_a      = random_op(op_add, sew16);
    op_b      = random_op(op_max, sew8);
    out_ready = 1'b0;
    in_op     = op_a;
    in_valid  = 1'b1;
    wait_accept();
    in_op = op_b;
    repeat (3) begin
        #1;
        check_value("out_valid", vec_data_t'(out_valid), vec_data_t'(1));
        check_value("in_ready", vec_data_t'(in_ready), vec_data_t'(0));
        check_value("out_res.data", out_res.data, expected_result(op_a, fwd_idle, fwd_idle));
        @(posedge clk);
        #1;
    end
    out_ready = 1'b1;
    wait_accept();
    in_valid = 1'b0;
    wait_result(res);
    check_value("out_res.data", res.data, expected_result(op_b, fwd_idle, fwd_idle));
endtask

`endif

//--- verification/tb_vec_execute.sv
// ====================
// Vector execute stage testbench top
// Clock, reset, DUT, reference model, watchdog
// ====================
`timescale 1ns/1ns
`default_nettype none

module tb_vec_execute;
    import vec_exe_pkg::*;

    localparam int clk_period = 4;
    // Operations applied by all tests together
    localparam int num_ops    = 236;
    localparam int timeout_ns = (num_ops * 20 + 100) * clk_period;
    localparam fwd_port_t fwd_idle = '0;

    logic        clk;
    logic        arst_n;
    vec_op_t     in_op;
    logic        in_valid;
    logic        out_ready;
    fwd_port_t   fwd_mem;
    fwd_port_t   fwd_wb;
    logic        in_ready;
    vec_result_t out_res;
    logic        out_valid;
    int          error_count;
    int          check_count;

    vec_execute dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_op     (in_op),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .in_ready  (in_ready),
        .out_res   (out_res),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic int elem_bits(sew_e sew);
        case (sew)
            sew8:    return 8;
            sew16:   return 16;
            default: return 32;
        endcase
    endfunction

    // Low element bits of val copied into every element
    function automatic vec_data_t replicate(xlen_data_t val, sew_e sew);
        vec_data_t vec;
        int        w;
        w = elem_bits(sew);
        for (int k = 0; k < vlen; k++) begin
            vec[k] = val[k % w];
        end
        return vec;
    endfunction

    // Newest register value with the memory stage first
    function automatic vec_data_t forwarded(reg_addr_t addr, vec_data_t own,
                                            fwd_port_t mem, fwd_port_t wb);
        return (mem.wr_en && mem.addr == addr) ? mem.data :
               (wb.wr_en && wb.addr == addr)   ? wb.data  : own;
    endfunction

    // One element of width w
    // Caller masks the result to w bits
    function automatic logic [63:0] element_op(vec_op_e opc, logic sgn, int w,
                                               logic [63:0] ea, logic [63:0] eb);
        longint sa;
        longint sb;
        int     sh;
        logic   lt;
        sa = ea[w-1] ? longint'(ea) - (longint'(1) << w) : longint'(ea);
        sb = eb[w-1] ? longint'(eb) - (longint'(1) << w) : longint'(eb);
        sh = int'(eb[4:0]) % w;
        lt = sgn ? (sa < sb) : (ea < eb);
        case (opc)
            op_add:  return ea + eb;
            op_sub:  return ea - eb;
            op_and:  return ea & eb;
            op_or:   return ea | eb;
            op_xor:  return ea ^ eb;
            op_sll:  return ea << sh;
            op_srl:  return ea >> sh;
            op_sra:  return 64'(sa >>> sh);
            op_min:  return lt ? ea : eb;
            default: return lt ? eb : ea;
        endcase
    endfunction

    function automatic vec_data_t expected_result(vec_op_t op, fwd_port_t mem, fwd_port_t wb);
        vec_data_t   a;
        vec_data_t   b;
        vec_data_t   mreg;
        vec_data_t   res;
        logic [63:0] lowmask;
        logic [63:0] ev;
        int          w;
        w       = elem_bits(op.sew);
        lowmask = (64'd1 << w) - 64'd1;
        a       = forwarded(op.srca_addr, op.srca, mem, wb);
        mreg    = forwarded(reg_addr_t'(0), op.mask_reg, mem, wb);
        res     = forwarded(op.vd_addr, op.vd_old, mem, wb);
        case (op.src_sel)
            src_vx:  b = replicate(op.scalar, op.sew);
            src_vi:  b = replicate({{(xlen-5){op.imm[4]}}, op.imm}, op.sew);
            default: b = forwarded(op.srcb_addr, op.srcb, mem, wb);
        endcase
        for (int i = 0; i < vlen / w; i++) begin
            if (i >= int'(op.vstart) && i < int'(op.vl) && (!op.use_mask || mreg[i])) begin
                ev  = element_op(op.op, op.is_signed, w, 64'(a >> (i*w)) & lowmask,
                                 64'(b >> (i*w)) & lowmask) & lowmask;
                res = (res & ~(vec_data_t'(lowmask) << (i*w))) | (vec_data_t'(ev) << (i*w));
            end
        end
        return res;
    endfunction

    `include "tb_vec_tests.svh"

    initial begin
        void'($urandom(37));
        error_count = 0;
        check_count = 0;
        in_op       = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        fwd_mem     = fwd_idle;
        fwd_wb      = fwd_idle;
        arst_n      = 1'b0;
        apply_reset();
        test_arith_logic();
        test_shift_minmax();
        test_mask_tail();
        test_broadcast();
        test_forwarding();
        test_handshake();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verification
src/vec_exe_pkg.sv
src/vec_bypass.sv
src/vec_element_ctrl.sv
src/vec_lane_alu.sv
src/vec_execute.sv
verification/tb_vec_execute.sv

//--- Makefile
# Verilator build and run for the vector execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_execute
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
